// File: hdl/mem_pkg.sv
// Shared memory map definitions
package mem_pkg;

	// Word address of the shared memory, 8K words
	localparam int MEM_ADDR_W = 13;

	// Region offsets inside the shared memory
	localparam int ROM_WORD_W = 12;
	localparam int RAM_WORD_W = 9;

	localparam int DATA_W = 16;

	// Host download buffer depth and credits after reset
	localparam int LOAD_CREDITS = 2;

	//////////////////////////////////////////////////////////////////////
	// Memory address, seen as ROM or as work RAM
	//////////////////////////////////////////////////////////////////////

	// Tag bit selects the half of the memory
	typedef union packed {
		struct packed {
			logic                  tag;
			logic [ROM_WORD_W-1:0] word;
		} rom;
		struct packed {
			logic                  tag;
			logic [2:0]            pad;
			logic [RAM_WORD_W-1:0] word;
		} ram;
	} mem_addr_u;

endpackage

// File: hdl/cart_pkg.sv
// Cartridge header definitions
package cart_pkg;

	// Byte address of the region byte in the header
	localparam logic [16:0] HDR_REGION_ADDR = 17'h001F0;

	// Region letters as they appear in the header
	localparam logic [7:0] HDR_CHAR_J = 8'h4A;
	localparam logic [7:0] HDR_CHAR_U = 8'h55;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

endpackage

// File: hdl/cart_loader.sv
// Cartridge download buffer
`timescale 1ns/1ns

module cart_loader (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        load_active,
	input  logic                        load_wr,
	input  logic [16:0]                 load_addr,
	input  logic [mem_pkg::DATA_W-1:0]  load_data,
	input  logic                        ld_done,
	output logic                        load_credit,
	output logic                        ld_req,
	output mem_pkg::mem_addr_u          ld_addr,
	output logic [mem_pkg::DATA_W-1:0]  ld_wdata
);

	// Buffered words, already swapped
	mem_pkg::mem_addr_u                  fifo_addr [mem_pkg::LOAD_CREDITS];
	logic [mem_pkg::DATA_W-1:0]          fifo_data [mem_pkg::LOAD_CREDITS];

	logic [$clog2(mem_pkg::LOAD_CREDITS)-1:0]   wr_ptr;
	logic [$clog2(mem_pkg::LOAD_CREDITS)-1:0]   rd_ptr;
	logic [$clog2(mem_pkg::LOAD_CREDITS+1)-1:0] count;

	logic               push;
	logic               ld_credit;
	mem_pkg::mem_addr_u push_addr;

	assign push = load_wr & load_active;

	// Download always lands in the ROM half
	always_comb begin
		push_addr.rom.tag = 1'b0;
		push_addr.rom.word = load_addr[mem_pkg::ROM_WORD_W:1];
	end

	always_ff @(posedge clk_sys) begin
		if (push) begin
			fifo_addr[wr_ptr] <= push_addr;
			fifo_data[wr_ptr] <= {load_data[7:0], load_data[15:8]};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pointers, fill level and controller credit
	//////////////////////////////////////////////////////////////////////

	// Head entry stays until the controller reports it written
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			ld_credit <= 1'b1;
			load_credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (ld_done)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, ld_done})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
			if (ld_req)
				ld_credit <= 1'b0;
			else if (ld_done)
				ld_credit <= 1'b1;
			// Slot freed, hand the credit back to the host
			load_credit <= ld_done;
		end
	end

	assign ld_req = ld_credit & (count != '0);
	assign ld_addr = fifo_addr[rd_ptr];
	assign ld_wdata = fifo_data[rd_ptr];

	// Host must respect its credits
	a_no_overflow: assert property (@(posedge clk_sys) disable iff (reset)
		load_wr |-> (count != mem_pkg::LOAD_CREDITS))
		else $error("cart_loader: host write while the download buffer is full");

endmodule

// File: hdl/console_port.sv
// Console CPU bus port
`timescale 1ns/1ns

module console_port (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        cpu_rom_sel,
	input  logic                        cpu_ram_sel,
	input  logic                        cpu_rd,
	input  logic                        cpu_wr_lo,
	input  logic                        cpu_wr_hi,
	input  logic [15:0]                 cpu_addr,
	input  logic [mem_pkg::DATA_W-1:0]  cpu_wdata,
	input  logic                        cp_done,
	input  logic [mem_pkg::DATA_W-1:0]  cp_rdata,
	output logic                        cpu_busy,
	output logic [mem_pkg::DATA_W-1:0]  cpu_rdata,
	output logic                        cp_req,
	output logic                        cp_we,
	output logic [1:0]                  cp_be,
	output mem_pkg::mem_addr_u          cp_addr,
	output logic [mem_pkg::DATA_W-1:0]  cp_wdata
);

	logic               strobe;
	logic               start;
	logic               acc_rd;
	mem_pkg::mem_addr_u req_addr;

	assign strobe = cpu_rd | cpu_wr_lo | cpu_wr_hi;
	// Busy low means the controller credit is back
	assign start = strobe & (cpu_rom_sel | cpu_ram_sel) & ~cpu_busy;

	// Select decides the tag, low bits give the offset
	always_comb begin
		if (cpu_ram_sel) begin
			req_addr.ram.tag = 1'b1;
			req_addr.ram.pad = 3'b000;
			req_addr.ram.word = cpu_addr[mem_pkg::RAM_WORD_W-1:0];
		end else begin
			req_addr.rom.tag = 1'b0;
			req_addr.rom.word = cpu_addr[mem_pkg::ROM_WORD_W-1:0];
		end
	end

	// Request payload
	always_ff @(posedge clk_sys) begin
		if (start) begin
			cp_addr <= req_addr;
			cp_wdata <= cpu_wdata;
			cp_we <= cpu_wr_lo | cpu_wr_hi;
			cp_be <= cpu_rd ? 2'b11 : {cpu_wr_hi, cpu_wr_lo};
		end
		if (cp_done && acc_rd)
			cpu_rdata <= cp_rdata;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cp_req <= 1'b0;
			cpu_busy <= 1'b0;
			acc_rd <= 1'b0;
		end else begin
			cp_req <= start;
			if (start) begin
				cpu_busy <= 1'b1;
				acc_rd <= cpu_rd;
			end else if (cp_done) begin
				cpu_busy <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// CPU bus rules
	//////////////////////////////////////////////////////////////////////

	a_rom_no_write: assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_wr_lo | cpu_wr_hi) |-> !cpu_rom_sel)
		else $error("console_port: write strobed into cartridge ROM");

	a_one_select: assert property (@(posedge clk_sys) disable iff (reset)
		(strobe && !cpu_busy) |-> (cpu_rom_sel ^ cpu_ram_sel))
		else $error("console_port: access strobe without exactly one select");

endmodule

// File: hdl/cart_mem_ctrl.sv
// Shared cartridge memory with round-robin arbiter
`timescale 1ns/1ns

module cart_mem_ctrl (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        ld_req,
	input  mem_pkg::mem_addr_u          ld_addr,
	input  logic [mem_pkg::DATA_W-1:0]  ld_wdata,
	input  logic                        cp_req,
	input  logic                        cp_we,
	input  logic [1:0]                  cp_be,
	input  mem_pkg::mem_addr_u          cp_addr,
	input  logic [mem_pkg::DATA_W-1:0]  cp_wdata,
	output logic                        ld_done,
	output logic                        cp_done,
	output logic [mem_pkg::DATA_W-1:0]  cp_rdata
);

	logic [mem_pkg::DATA_W-1:0] mem [2**mem_pkg::MEM_ADDR_W];

	// Held requests of the peer that lost
	logic                       ld_pend, cp_pend;
	mem_pkg::mem_addr_u         ld_addr_q, cp_addr_q;
	logic [mem_pkg::DATA_W-1:0] ld_wdata_q, cp_wdata_q;
	logic                       cp_we_q;
	logic [1:0]                 cp_be_q;

	// Candidates from a fresh strobe or a held request
	logic                       ld_want, cp_want, grant_cp, rr_cp;
	mem_pkg::mem_addr_u         ld_addr_c, cp_addr_c;
	logic [mem_pkg::DATA_W-1:0] ld_wdata_c, cp_wdata_c;
	logic                       cp_we_c;
	logic [1:0]                 cp_be_c;

	// Access stage
	logic                       acc_valid, acc_cp, acc_we;
	logic [1:0]                 acc_be;
	mem_pkg::mem_addr_u         acc_addr;
	logic [mem_pkg::DATA_W-1:0] acc_wdata;

	assign ld_want = ld_req | ld_pend;
	assign cp_want = cp_req | cp_pend;
	// rr_cp gives the console priority on the next conflict
	assign grant_cp = cp_want & (~ld_want | rr_cp);

	assign ld_addr_c = ld_pend ? ld_addr_q : ld_addr;
	assign ld_wdata_c = ld_pend ? ld_wdata_q : ld_wdata;
	assign cp_addr_c = cp_pend ? cp_addr_q : cp_addr;
	assign cp_wdata_c = cp_pend ? cp_wdata_q : cp_wdata;
	assign cp_we_c = cp_pend ? cp_we_q : cp_we;
	assign cp_be_c = cp_pend ? cp_be_q : cp_be;

	//////////////////////////////////////////////////////////////////////
	// Arbitration
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ld_pend <= 1'b0;
			cp_pend <= 1'b0;
			rr_cp <= 1'b0;
			acc_valid <= 1'b0;
			ld_done <= 1'b0;
			cp_done <= 1'b0;
		end else begin
			ld_pend <= ld_want & grant_cp;
			cp_pend <= cp_want & ~grant_cp;
			if (ld_want && cp_want)
				rr_cp <= ~grant_cp;
			acc_valid <= ld_want | cp_want;
			ld_done <= acc_valid & ~acc_cp;
			cp_done <= acc_valid & acc_cp;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ld_req) begin
			ld_addr_q <= ld_addr;
			ld_wdata_q <= ld_wdata;
		end
		if (cp_req) begin
			cp_addr_q <= cp_addr;
			cp_wdata_q <= cp_wdata;
			cp_we_q <= cp_we;
			cp_be_q <= cp_be;
		end
		// Loader writes are always full words
		acc_cp <= grant_cp;
		acc_we <= grant_cp ? cp_we_c : 1'b1;
		acc_be <= grant_cp ? cp_be_c : 2'b11;
		acc_addr <= grant_cp ? cp_addr_c : ld_addr_c;
		acc_wdata <= grant_cp ? cp_wdata_c : ld_wdata_c;
	end

	//////////////////////////////////////////////////////////////////////
	// Word memory, byte lanes and registered read
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (acc_valid) begin
			if (acc_we && acc_be[0])
				mem[acc_addr][7:0] <= acc_wdata[7:0];
			if (acc_we && acc_be[1])
				mem[acc_addr][15:8] <= acc_wdata[15:8];
			cp_rdata <= mem[acc_addr];
		end
	end

	// A peer strobes only while it holds its credit
	a_credit_held: assert property (@(posedge clk_sys) disable iff (reset)
		!(ld_req && (ld_pend || (acc_valid && !acc_cp)))
		&& !(cp_req && (cp_pend || (acc_valid && acc_cp))))
		else $error("cart_mem_ctrl: peer strobed a request without its credit");

endmodule

// File: hdl/region_detect.sv
// Cartridge region detector
`timescale 1ns/1ns

module region_detect (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        load_active,
	input  logic                        load_wr,
	input  logic [16:0]                 load_addr,
	input  logic [mem_pkg::DATA_W-1:0]  load_data,
	output cart_pkg::region_t           region,
	output logic                        region_valid
);

	logic               active_q;
	logic               hdr_wr;
	cart_pkg::region_t  hdr_region;

	assign hdr_wr = load_active & load_wr & (load_addr == cart_pkg::HDR_REGION_ADDR);

	// Host word is still unswapped here, region byte sits low
	always_comb begin
		case (load_data[7:0])
			cart_pkg::HDR_CHAR_J: hdr_region = cart_pkg::REGION_JP;
			cart_pkg::HDR_CHAR_U: hdr_region = cart_pkg::REGION_US;
			default:              hdr_region = cart_pkg::REGION_EU;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q <= 1'b0;
			region <= cart_pkg::REGION_JP;
			region_valid <= 1'b0;
		end else begin
			active_q <= load_active;
			// New download, old header no longer counts
			if (load_active && !active_q)
				region_valid <= 1'b0;
			if (hdr_wr) begin
				region <= hdr_region;
				region_valid <= 1'b1;
			end
		end
	end

endmodule

// File: hdl/cart_sys.sv
// Cartridge memory subsystem top
`timescale 1ns/1ns

module cart_sys (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        load_active,
	input  logic                        load_wr,
	input  logic [16:0]                 load_addr,
	input  logic [mem_pkg::DATA_W-1:0]  load_data,
	output logic                        load_credit,
	input  logic                        cpu_rom_sel,
	input  logic                        cpu_ram_sel,
	input  logic                        cpu_rd,
	input  logic                        cpu_wr_lo,
	input  logic                        cpu_wr_hi,
	input  logic [15:0]                 cpu_addr,
	input  logic [mem_pkg::DATA_W-1:0]  cpu_wdata,
	output logic                        cpu_busy,
	output logic [mem_pkg::DATA_W-1:0]  cpu_rdata,
	output cart_pkg::region_t           region,
	output logic                        region_valid
);

	// Loader to controller
	logic                       ld_req, ld_done;
	mem_pkg::mem_addr_u         ld_addr;
	logic [mem_pkg::DATA_W-1:0] ld_wdata;

	// Console port to controller
	logic                       cp_req, cp_we, cp_done;
	logic [1:0]                 cp_be;
	mem_pkg::mem_addr_u         cp_addr;
	logic [mem_pkg::DATA_W-1:0] cp_wdata, cp_rdata;

	cart_loader loader (
		.clk_sys(clk_sys), .reset(reset),
		.load_active(load_active), .load_wr(load_wr),
		.load_addr(load_addr), .load_data(load_data),
		.ld_done(ld_done), .load_credit(load_credit),
		.ld_req(ld_req), .ld_addr(ld_addr), .ld_wdata(ld_wdata)
	);

	console_port cpu_port (
		.clk_sys(clk_sys), .reset(reset),
		.cpu_rom_sel(cpu_rom_sel), .cpu_ram_sel(cpu_ram_sel),
		.cpu_rd(cpu_rd), .cpu_wr_lo(cpu_wr_lo), .cpu_wr_hi(cpu_wr_hi),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.cp_done(cp_done), .cp_rdata(cp_rdata),
		.cpu_busy(cpu_busy), .cpu_rdata(cpu_rdata),
		.cp_req(cp_req), .cp_we(cp_we), .cp_be(cp_be),
		.cp_addr(cp_addr), .cp_wdata(cp_wdata)
	);

	cart_mem_ctrl mem_ctrl (
		.clk_sys(clk_sys), .reset(reset),
		.ld_req(ld_req), .ld_addr(ld_addr), .ld_wdata(ld_wdata),
		.cp_req(cp_req), .cp_we(cp_we), .cp_be(cp_be),
		.cp_addr(cp_addr), .cp_wdata(cp_wdata),
		.ld_done(ld_done), .cp_done(cp_done), .cp_rdata(cp_rdata)
	);

	region_detect hdr_region (
		.clk_sys(clk_sys), .reset(reset),
		.load_active(load_active), .load_wr(load_wr),
		.load_addr(load_addr), .load_data(load_data),
		.region(region), .region_valid(region_valid)
	);

endmodule

// File: sim/tb_cart_checks.svh
// Testbench checks and error counters

int value_errors = 0;
int protocol_errors = 0;

//////////////////////////////////////////////////////////////////////
// Reset and host credits
//////////////////////////////////////////////////////////////////////

reset_idle: assert property (@(posedge clk_sys)
	$fell(reset) |-> (!load_credit && !cpu_busy && !region_valid
		&& region == cart_pkg::REGION_JP))
	else begin
		protocol_errors++;
		$display("Outputs were not idle when reset was released");
	end

// A returned credit always belongs to a word already sent
credit_bound: assert property (@(posedge clk_sys) disable iff (reset)
	load_credit |-> (credits_back < words_sent))
	else begin
		protocol_errors++;
		$display("Host got a credit back for a word it never wrote");
	end

//////////////////////////////////////////////////////////////////////
// Console read data
//////////////////////////////////////////////////////////////////////

read_data: assert property (@(posedge clk_sys) disable iff (reset)
	($fell(cpu_busy) && rd_check) |-> (cpu_rdata == rd_expect))
	else begin
		value_errors++;
		$display("** Error [%s] expected %h, actual %h", test_name,
			$sampled(rd_expect), $sampled(cpu_rdata));
	end

//////////////////////////////////////////////////////////////////////
// Region detection
//////////////////////////////////////////////////////////////////////

region_value: assert property (@(posedge clk_sys) disable iff (reset)
	(load_active && load_wr && load_addr == cart_pkg::HDR_REGION_ADDR)
		|=> (region_valid && region == region_expect))
	else begin
		value_errors++;
		$display("** Error [region download %0d] expected %0d valid 1, actual %0d valid %b",
			dl_index, $sampled(region_expect), $sampled(region), $sampled(region_valid));
	end

valid_clear: assert property (@(posedge clk_sys) disable iff (reset)
	$rose(load_active) |=> !region_valid)
	else begin
		protocol_errors++;
		$display("region_valid stayed high after download %0d started", dl_index);
	end

// File: sim/tb_cart_sys.sv
// Cartridge memory subsystem testbench
`timescale 1ns/1ns

module tb_cart_sys;

	localparam int DL_WORDS = 256;
	localparam int HDR_WORD = int'(cart_pkg::HDR_REGION_ADDR >> 1);
	localparam int ROM_READS = 24;
	localparam int RAM_ROUNDS = 8;
	localparam int CONTEND_READS = 40;
	// Each RAM round is three writes and four reads
	localparam int N_OPS = 3 * DL_WORDS + ROM_READS + 7 * RAM_ROUNDS + CONTEND_READS;
	localparam int TIMEOUT_CYCLES = 4 * N_OPS * 2;

	logic clk_sys;
	logic reset;
	logic load_active, load_wr, load_credit;
	logic [16:0] load_addr;
	logic [15:0] load_data;
	logic cpu_rom_sel, cpu_ram_sel, cpu_rd, cpu_wr_lo, cpu_wr_hi, cpu_busy;
	logic [15:0] cpu_addr, cpu_wdata, cpu_rdata;
	cart_pkg::region_t region;
	logic region_valid;

	// Reference model and bookkeeping
	logic [15:0] rom_ref [DL_WORDS];
	logic [15:0] ram_ref [DL_WORDS];
	int words_sent = 0;
	int credits_back = 0;
	int dl_base = 0;
	int dl_index = 0;
	int cycle_count = 0;
	logic rd_check = 1'b0;
	logic [15:0] rd_expect = '0;
	string test_name = "idle";
	cart_pkg::region_t region_expect = cart_pkg::REGION_JP;

	cart_sys UUT (.*);

	`include "tb_cart_checks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (!reset && load_credit)
			credits_back <= credits_back + 1;
	end

	// Header letter to region, J and U named, anything else Europe
	function automatic cart_pkg::region_t region_of(input logic [7:0] c);
		if (c == "J")
			return cart_pkg::REGION_JP;
		if (c == "U")
			return cart_pkg::REGION_US;
		return cart_pkg::REGION_EU;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Host download
	//////////////////////////////////////////////////////////////////////

	// Holds off while every credit is spent
	task automatic send_word(input int word, input logic [15:0] data);
		@(posedge clk_sys);
		while (words_sent - credits_back >= mem_pkg::LOAD_CREDITS) begin
			load_wr <= 1'b0;
			@(posedge clk_sys);
		end
		load_wr <= 1'b1;
		load_addr <= 17'(word * 2);
		load_data <= data;
		words_sent++;
		rom_ref[word] = {data[7:0], data[15:8]};
	endtask

	task automatic download_image(input int index, input logic [7:0] hdr_char);
		logic [15:0] data;
		@(posedge clk_sys);
		dl_index <= index;
		region_expect <= region_of(hdr_char);
		load_active <= 1'b1;
		for (int w = 0; w < DL_WORDS; w++) begin
			data = 16'($urandom);
			if (w == HDR_WORD)
				data[7:0] = hdr_char;
			send_word(w, data);
		end
		@(posedge clk_sys);
		load_wr <= 1'b0;
		// Drain, every buffered word hands its credit back
		while (credits_back != words_sent)
			@(posedge clk_sys);
		load_active <= 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Console bus
	//////////////////////////////////////////////////////////////////////

	task automatic cpu_access(input string name, input bit ram, input bit rd, input bit lo,
		input bit hi, input int word, input logic [15:0] wdata, input logic [15:0] exp_val);
		@(posedge clk_sys);
		cpu_rom_sel <= !ram;
		cpu_ram_sel <= ram;
		cpu_rd <= rd;
		cpu_wr_lo <= lo;
		cpu_wr_hi <= hi;
		cpu_addr <= 16'(word);
		cpu_wdata <= wdata;
		test_name <= name;
		rd_check <= rd;
		rd_expect <= exp_val;
		@(posedge clk_sys);
		{cpu_rom_sel, cpu_ram_sel, cpu_rd, cpu_wr_lo, cpu_wr_hi} <= '0;
		do
			@(posedge clk_sys);
		while (cpu_busy);
	endtask

	task automatic ram_lane_test(input int word);
		logic [15:0] v;
		v = 16'($urandom);
		ram_ref[word] = v;
		cpu_access("ram full write", 1, 0, 1, 1, word, v, 16'h0000);
		cpu_access("ram full word", 1, 1, 0, 0, word, 16'h0000, ram_ref[word]);
		v = 16'($urandom);
		ram_ref[word][7:0] = v[7:0];
		cpu_access("ram low write", 1, 0, 1, 0, word, v, 16'h0000);
		cpu_access("ram low lane", 1, 1, 0, 0, word, 16'h0000, ram_ref[word]);
		v = 16'($urandom);
		ram_ref[word][15:8] = v[15:8];
		cpu_access("ram high write", 1, 0, 0, 1, word, v, 16'h0000);
		cpu_access("ram high lane", 1, 1, 0, 0, word, 16'h0000, ram_ref[word]);
		cpu_access("rom after ram write", 0, 1, 0, 0, word, 16'h0000, rom_ref[word]);
	endtask

	// Only words whose credit came back are settled in memory
	task automatic contention_reads(input int count);
		int done_words;
		int word;
		int issued;
		issued = 0;
		while (issued < count) begin
			@(posedge clk_sys);
			done_words = credits_back - dl_base;
			if (done_words > 0) begin
				word = $urandom_range(done_words - 1, 0);
				cpu_access("contention read", 0, 1, 0, 0, word, 16'h0000, rom_ref[word]);
				issued++;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int word;
		void'($urandom(14944));
		reset <= 1'b1;
		load_active <= 1'b0;
		load_wr <= 1'b0;
		load_addr <= '0;
		load_data <= '0;
		{cpu_rom_sel, cpu_ram_sel, cpu_rd, cpu_wr_lo, cpu_wr_hi} <= '0;
		cpu_addr <= '0;
		cpu_wdata <= '0;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;

		download_image(1, "J");
		for (int i = 0; i < ROM_READS; i++) begin
			word = $urandom_range(DL_WORDS - 1, 0);
			cpu_access("rom readback", 0, 1, 0, 0, word, 16'h0000, rom_ref[word]);
		end
		for (int i = 0; i < RAM_ROUNDS; i++)
			ram_lane_test($urandom_range(DL_WORDS - 1, 0));

		download_image(2, "U");
		dl_base = words_sent;
		fork
			download_image(3, 8'h45);
			contention_reads(CONTEND_READS);
		join

		repeat (4) @(posedge clk_sys);
		$display("Summary: %0d value errors, %0d protocol errors", value_errors,
			protocol_errors);
		if (value_errors + protocol_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Credits or cpu_busy stuck
	initial begin
		wait (cycle_count == TIMEOUT_CYCLES);
		$display("Timeout after %0d cycles, a credit or cpu_busy never came back",
			cycle_count);
		$display("Summary: %0d value errors, %0d protocol errors", value_errors,
			protocol_errors);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: cart_sys.f
hdl/mem_pkg.sv
hdl/cart_pkg.sv
hdl/cart_loader.sv
hdl/console_port.sv
hdl/cart_mem_ctrl.sv
hdl/region_detect.sv
hdl/cart_sys.sv
+incdir+sim
sim/tb_cart_sys.sv
